// ==== vlog.f ====
src/chess_pkg.sv
src/bus_pkg.sv
src/ray_if.sv
src/csr_regs.sv
src/ray_scanner.sv
src/board_mover.sv
src/queen_top.sv
dv/queen_chk.sv
dv/queen_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module queen_tb -f vlog.f -o queen_sim

./obj_dir/queen_sim | tee sim.log

# the run passes only if the testbench printed its pass line
grep -qx "No errors" sim.log

// ==== dv/queen_tb.sv ====
`timescale 1ns/10ps

module queen_tb import bus_pkg::*; ();

    // at most 27 moves in tests 1, 17 in tests 2 and 4, none in test 3
    localparam int words_total = (64 + 64 * 27) + 2 * (64 + 64 * 17) + 64;
    localparam int worst_stall = 16;
    localparam int timeout_cycles = words_total * worst_stall + 2000;

    logic                  clk;
    logic                  rst_n;
    logic [reg_addr_w-1:0] slave_address;
    logic                  slave_read;
    logic                  slave_write;
    logic [bus_w-1:0]      slave_writedata;
    logic                  slave_waitrequest;
    logic [bus_w-1:0]      slave_readdata;
    logic                  master_waitrequest;
    logic [bus_w-1:0]      master_readdata;
    logic                  master_readdatavalid;
    logic [31:0]           master_address;
    logic                  master_read;
    logic                  master_write;
    logic [bus_w-1:0]      master_writedata;

    logic signed [7:0] image [64];
    int                exp_targets [$];
    int                origin_sq;
    logic [31:0]       src_base;
    logic [31:0]       dest_base;
    int                wr_count = 0;
    int                errors = 0;
    int                tests_run = 0;
    int                cycles = 0;
    bit                rand_wait = 1'b0;
    bit                rd_pending = 1'b0;
    int                rd_wait = 0;
    logic [7:0]        rd_data;
    logic [31:0]       lfsr = 32'h45aa_d0a9;

    queen_top #(.addr_w(32)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic next_random_bit();
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        return lfsr[0];
    endfunction

    task automatic log_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    // targets in ray order, nearest square first
    function automatic void build_targets(input int org);
        int df [8];
        int dr [8];
        int x;
        int y;
        int own;
        int col;
        df = '{0, 0, -1, 1, 1, 1, -1, -1};
        dr = '{1, -1, 0, 0, 1, -1, 1, -1};
        exp_targets.delete();
        own = (image[org] > 0) ? 1 : (image[org] < 0) ? -1 : 0;
        if (own == 0) begin
            return;
        end
        for (int r = 0; r < 8; r++) begin
            x = org % 8 + df[r];
            y = org / 8 + dr[r];
            while (x >= 0 && x < 8 && y >= 0 && y < 8) begin
                col = (image[y * 8 + x] > 0) ? 1 : (image[y * 8 + x] < 0) ? -1 : 0;
                if (col == own) begin
                    break;
                end
                exp_targets.push_back(y * 8 + x);
                if (col != 0) begin
                    break;
                end
                x += df[r];
                y += dr[r];
            end
        end
    endfunction

    function automatic logic [7:0] expected_word(input int n, input int idx);
        if (idx == origin_sq) begin
            return 8'h00;
        end
        if (idx == exp_targets[n]) begin
            return image[origin_sq];
        end
        return image[idx];
    endfunction

    // memory model, sampled at the edge and driven 1 ns after it
    always @(posedge clk) begin : mem_model
        logic [31:0] off;
        if (master_read && !master_waitrequest) begin
            off = master_address - src_base;
            rd_data = image[off[5:0]];
            rd_wait = {next_random_bit(), next_random_bit()};
            rd_wait = (rd_wait == 3) ? 1 : rd_wait + 1;
            rd_pending = 1'b1;
        end
        if (master_write && !master_waitrequest) begin
            assert (master_address == dest_base + wr_count)
                else log_fail($sformatf("write address %h, expected %h", master_address,
                                        dest_base + wr_count));
            if (wr_count / 64 < exp_targets.size()) begin
                assert (master_writedata[7:0] == expected_word(wr_count / 64, wr_count % 64))
                    else log_fail($sformatf("board %0d square %0d is %h, expected %h",
                                            wr_count / 64, wr_count % 64, master_writedata[7:0],
                                            expected_word(wr_count / 64, wr_count % 64)));
            end else begin
                log_fail("write past the last successor board");
            end
            wr_count++;
        end
        #1;
        master_readdatavalid = 1'b0;
        master_readdata = '0;
        if (rd_pending) begin
            if (rd_wait == 1) begin
                master_readdatavalid = 1'b1;
                master_readdata = {{24{rd_data[7]}}, rd_data};
                rd_pending = 1'b0;
            end else begin
                rd_wait--;
            end
        end
        master_waitrequest = rand_wait ? next_random_bit() : 1'b0;
    end

    task automatic csr_write(input logic [reg_addr_w-1:0] addr, input logic [31:0] data);
        slave_address = addr;
        slave_writedata = data;
        slave_write = 1'b1;
        @(posedge clk);
        while (slave_waitrequest) @(posedge clk);
        #1 slave_write = 1'b0;
    endtask

    // stalls while a run is busy
    task automatic csr_read(input logic [reg_addr_w-1:0] addr, output logic [31:0] data);
        slave_address = addr;
        slave_read = 1'b1;
        @(posedge clk);
        while (slave_waitrequest) @(posedge clk);
        data = slave_readdata;
        #1 slave_read = 1'b0;
    endtask

    task automatic run_case(input int id, input string name, input int file, input int rank,
                            input bit noisy);
        logic [31:0] got;
        int          errors_before;
        errors_before = errors;
        origin_sq = rank * 8 + file;
        src_base = 32'h0000_1000 + id * 32'h100;
        dest_base = 32'h0002_0000 + id * 32'h1000;
        build_targets(origin_sq);
        wr_count = 0;
        rand_wait = noisy;
        csr_write(reg_src, src_base);
        csr_write(reg_dest, dest_base);
        csr_write(reg_file, file);
        csr_write(reg_rank, rank);
        csr_write(reg_start, 32'd0);
        csr_read(reg_start, got);
        assert (got == exp_targets.size())
            else log_fail($sformatf("move count %0d, expected %0d", got, exp_targets.size()));
        assert (wr_count == 64 * exp_targets.size())
            else log_fail($sformatf("%0d words written, expected %0d", wr_count,
                                    64 * exp_targets.size()));
        tests_run++;
        $display("test %0d (%s): %0d boards, %0d failed checks", id, name,
                 exp_targets.size(), errors - errors_before);
    endtask

    task automatic place(input int file, input int rank, input logic signed [7:0] code);
        image[rank * 8 + file] = code;
    endtask

    initial begin : watchdog
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT did not finish within %0d cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int unsigned total;
        rst_n = 1'b0;
        slave_address = '0;
        slave_read = 1'b0;
        slave_write = 1'b0;
        slave_writedata = '0;
        master_waitrequest = 1'b0;
        master_readdata = '0;
        master_readdatavalid = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        image = '{default: 8'sd0};
        place(3, 3, 8'sd5);
        run_case(1, "open board", 3, 3, 1'b0);

        // friendly pawns block, black pieces are captured
        place(3, 5, 8'sd1);
        place(5, 5, 8'sd1);
        place(3, 2, -8'sd1);
        place(6, 3, -8'sd3);
        place(1, 1, -8'sd4);
        run_case(2, "blocks and captures", 3, 3, 1'b0);
        run_case(4, "same board, random stalls", 3, 3, 1'b1);

        image = '{default: 8'sd0};
        place(0, 0, -8'sd5);
        place(1, 0, -8'sd1);
        place(0, 1, -8'sd1);
        place(1, 1, -8'sd1);
        place(6, 6, 8'sd2);
        run_case(3, "boxed in corner", 0, 0, 1'b1);

        total = errors + dut_i.chk_i.fails;
        $display("tests run %0d, failed checks %0d", tests_run, total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== dv/queen_chk.sv ====
`timescale 1ns/10ps

module queen_chk import bus_pkg::*; #(
    parameter int addr_w = 32
) (
    input logic              clk,
    input logic              rst_n,
    input logic              run_start,
    input logic              run_done,
    input logic [addr_w-1:0] src,
    input logic              master_read,
    input logic              master_write,
    input logic              master_waitrequest,
    input logic              master_readdatavalid,
    input logic [addr_w-1:0] master_address,
    input logic [bus_w-1:0]  master_writedata,
    input logic              slave_waitrequest
);

    logic [6:0]  rd_cnt;
    int unsigned fails = 0;

    // squares returned so far in the current run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else if (run_start) begin
            rd_cnt <= '0;
        end else if (master_readdatavalid && rd_cnt != 7'd64) begin
            rd_cnt <= rd_cnt + 7'd1;
        end
    end

    rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(master_read && master_write))
        else begin
            fails++;
            $error("master_read and master_write are high together");
        end

    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        master_read && master_waitrequest |=> master_read && $stable(master_address))
        else begin
            fails++;
            $error("read request changed while stalled");
        end

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        master_write && master_waitrequest |=>
            master_write && $stable(master_address) && $stable(master_writedata))
        else begin
            fails++;
            $error("write address or data changed while stalled");
        end

    // one read outstanding, so the next address is src plus the squares seen
    load_order: assert property (@(posedge clk) disable iff (!rst_n)
        master_read |-> master_address == src + addr_w'(rd_cnt))
        else begin
            fails++;
            $error("board load address out of order");
        end

    wr_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        master_write |-> rd_cnt == 7'd64)
        else begin
            fails++;
            $error("write issued before the whole board was loaded");
        end

    idle_after_run: assert property (@(posedge clk) disable iff (!rst_n)
        run_done |=> !slave_waitrequest)
        else begin
            fails++;
            $error("slave port still busy after the run ended");
        end

endmodule

bind queen_top queen_chk #(.addr_w(addr_w)) chk_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .run_start            (run_start),
    .run_done             (run_done),
    .src                  (src),
    .master_read          (master_read),
    .master_write         (master_write),
    .master_waitrequest   (master_waitrequest),
    .master_readdatavalid (master_readdatavalid),
    .master_address       (master_address),
    .master_writedata     (master_writedata),
    .slave_waitrequest    (slave_waitrequest)
);

// ==== src/queen_top.sv ====
`timescale 1ns/10ps

module queen_top import chess_pkg::*; import bus_pkg::*; #(
    parameter int addr_w = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] slave_address,
    input  logic                  slave_read,
    input  logic                  slave_write,
    input  logic [bus_w-1:0]      slave_writedata,
    output logic                  slave_waitrequest,
    output logic [bus_w-1:0]      slave_readdata,
    input  logic                  master_waitrequest,
    input  logic [bus_w-1:0]      master_readdata,
    input  logic                  master_readdatavalid,
    output logic [addr_w-1:0]     master_address,
    output logic                  master_read,
    output logic                  master_write,
    output logic [bus_w-1:0]      master_writedata
);

    logic               run_start;
    logic               run_done;
    logic [count_w-1:0] move_count;
    logic [addr_w-1:0]  src;
    logic [addr_w-1:0]  dest;
    sq_idx_t            origin;

    ray_if orth_ray ();
    ray_if diag_ray ();

    csr_regs #(.addr_w(addr_w)) csr_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .slave_address     (slave_address),
        .slave_read        (slave_read),
        .slave_write       (slave_write),
        .slave_writedata   (slave_writedata),
        .slave_waitrequest (slave_waitrequest),
        .slave_readdata    (slave_readdata),
        .run_done          (run_done),
        .move_count        (move_count),
        .start             (run_start),
        .src               (src),
        .dest              (dest),
        .origin            (origin)
    );

    // rank and file rays
    ray_scanner #(.diagonal(1'b0)) orth_scan_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ray   (orth_ray.scanner)
    );

    ray_scanner #(.diagonal(1'b1)) diag_scan_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ray   (diag_ray.scanner)
    );

    board_mover #(.addr_w(addr_w)) mover_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start                (run_start),
        .src                  (src),
        .dest                 (dest),
        .origin               (origin),
        .master_waitrequest   (master_waitrequest),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_write         (master_write),
        .master_writedata     (master_writedata),
        .orth                 (orth_ray.mover),
        .diag                 (diag_ray.mover),
        .run_done             (run_done),
        .move_count           (move_count)
    );

endmodule

// ==== src/board_mover.sv ====
`timescale 1ns/10ps

module board_mover import chess_pkg::*; import bus_pkg::*; #(
    parameter int addr_w = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [addr_w-1:0]  src,
    input  logic [addr_w-1:0]  dest,
    input  sq_idx_t            origin,
    input  logic               master_waitrequest,
    input  logic [bus_w-1:0]   master_readdata,
    input  logic               master_readdatavalid,
    output logic [addr_w-1:0]  master_address,
    output logic               master_read,
    output logic               master_write,
    output logic [bus_w-1:0]   master_writedata,
    ray_if.mover               orth,
    ray_if.mover               diag,
    output logic               run_done,
    output logic [count_w-1:0] move_count
);

    typedef enum logic [2:0] {
        st_idle,
        st_load_rd,
        st_load_wait,
        st_launch,
        st_serve,
        st_write
    } state_t;

    state_t             state;
    square_t            board [board_squares];
    square_t            queen_q;
    square_t            wr_sq;
    sq_idx_t            word_idx;
    sq_idx_t            target_q;
    sq_idx_t            cur_sq;
    colour_t            own_colour;
    logic               serve_diag;
    logic               cur_valid;
    logic               all_done;
    logic               last_word;
    logic [count_w-1:0] move_cnt;

    assign own_colour = square_colour(queen_q);
    assign last_word  = word_idx == sq_idx_t'(board_squares - 1);

    assign orth.start      = state == st_launch;
    assign orth.origin     = origin;
    assign orth.own_colour = own_colour;
    assign orth.probe_data = board[orth.probe_sq];
    assign diag.start      = state == st_launch;
    assign diag.origin     = origin;
    assign diag.own_colour = own_colour;
    assign diag.probe_data = board[diag.probe_sq];

    // orthogonal targets first, the diagonal scanner waits on its first one
    assign cur_valid = serve_diag ? diag.target_valid : orth.target_valid;
    assign cur_sq    = serve_diag ? diag.target_sq : orth.target_sq;
    assign orth.taken = state == st_serve && !serve_diag && orth.target_valid;
    assign diag.taken = state == st_serve && serve_diag && diag.target_valid;

    assign all_done = serve_diag && orth.scan_done && diag.scan_done && !diag.target_valid;
    assign run_done = state == st_serve && all_done;
    assign move_count = move_cnt;

    assign master_read  = state == st_load_rd;
    assign master_write = state == st_write;

    // successor board n lives at dest + 64 * n
    always_comb begin
        if (state == st_write) begin
            master_address = dest + addr_w'({move_cnt, word_idx});
        end else begin
            master_address = src + addr_w'(word_idx);
        end
    end

    always_comb begin
        if (word_idx == origin) begin
            wr_sq = '0;
        end else if (word_idx == target_q) begin
            wr_sq = queen_q;
        end else begin
            wr_sq = board[word_idx];
        end
    end

    assign master_writedata = bus_w'(wr_sq.code);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            word_idx   <= '0;
            serve_diag <= 1'b0;
            move_cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        word_idx   <= '0;
                        serve_diag <= 1'b0;
                        move_cnt   <= '0;
                        state      <= st_load_rd;
                    end
                end
                st_load_rd: begin
                    if (!master_waitrequest) begin
                        state <= st_load_wait;
                    end
                end
                st_load_wait: begin
                    // word_idx wraps to 0 after the last square
                    if (master_readdatavalid) begin
                        word_idx <= word_idx + 6'd1;
                        state    <= last_word ? st_launch : st_load_rd;
                    end
                end
                st_launch: state <= st_serve;
                st_serve: begin
                    if (cur_valid) begin
                        state <= st_write;
                    end else if (!serve_diag && orth.scan_done) begin
                        serve_diag <= 1'b1;
                    end else if (all_done) begin
                        state <= st_idle;
                    end
                end
                st_write: begin
                    if (!master_waitrequest) begin
                        word_idx <= word_idx + 6'd1;
                        if (last_word) begin
                            move_cnt <= move_cnt + count_w'(1);
                            state    <= st_serve;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // board store, queen code and the target being written
    always_ff @(posedge clk) begin
        if (state == st_load_wait && master_readdatavalid) begin
            board[word_idx] <= master_readdata[7:0];
            if (word_idx == origin) begin
                queen_q <= master_readdata[7:0];
            end
        end
        if (state == st_serve && cur_valid) begin
            target_q <= cur_sq;
        end
    end

endmodule

// ==== src/ray_scanner.sv ====
`timescale 1ns/10ps

module ray_scanner import chess_pkg::*; #(
    parameter bit diagonal = 1'b0
) (
    input  logic   clk,
    input  logic   rst_n,
    ray_if.scanner ray
);

    typedef enum logic [1:0] {
        st_idle,
        st_seek,
        st_walk,
        st_offer
    } state_t;

    state_t  state;
    logic [1:0] ray_q;
    coord_t  cur_x;
    coord_t  cur_y;
    coord_t  org_x;
    coord_t  org_y;
    coord_t  step_x;
    coord_t  step_y;
    logic    on_board;
    logic    blocked;
    logic    capture_q;
    logic    ray_end;
    colour_t probe_colour;

    assign org_x = coord_t'({2'b00, ray.origin[2:0]});
    assign org_y = coord_t'({2'b00, ray.origin[5:3]});

    assign step_x = ray_df[diagonal][ray_q];
    assign step_y = ray_dr[diagonal][ray_q];

    // 0..7 have both top bits clear, -1 and 8 do not
    assign on_board = cur_x[4:3] == 2'b00 && cur_y[4:3] == 2'b00;

    assign ray.probe_sq = {cur_y[2:0], cur_x[2:0]};
    assign probe_colour = square_colour(ray.probe_data);

    // an empty origin has no colour to move, so every ray ends at once
    assign blocked = !on_board || ray.own_colour == colour_empty ||
                     probe_colour == ray.own_colour;

    // a capture is offered once, then the ray stops behind it
    assign ray_end = (state == st_walk && blocked) ||
                     (state == st_offer && ray.taken && capture_q);

    // target stays put while offered, it is the probed square
    assign ray.target_valid = state == st_offer;
    assign ray.target_sq    = ray.probe_sq;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= st_idle;
            ray_q         <= '0;
            cur_x         <= '0;
            cur_y         <= '0;
            capture_q     <= 1'b0;
            ray.scan_done <= 1'b0;
        end else if (ray.start) begin
            state         <= st_seek;
            ray_q         <= '0;
            ray.scan_done <= 1'b0;
        end else if (ray_end) begin
            if (ray_q == 2'd3) begin
                state         <= st_idle;
                ray.scan_done <= 1'b1;
            end else begin
                ray_q <= ray_q + 2'd1;
                state <= st_seek;
            end
        end else begin
            case (state)
                st_seek: begin
                    cur_x <= org_x + step_x;
                    cur_y <= org_y + step_y;
                    state <= st_walk;
                end
                st_walk: begin
                    capture_q <= probe_colour != colour_empty;
                    state     <= st_offer;
                end
                st_offer: begin
                    // empty square taken, keep walking
                    if (ray.taken) begin
                        cur_x <= cur_x + step_x;
                        cur_y <= cur_y + step_y;
                        state <= st_walk;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/csr_regs.sv ====
`timescale 1ns/10ps

module csr_regs import chess_pkg::*; import bus_pkg::*; #(
    parameter int addr_w = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] slave_address,
    input  logic                  slave_read,
    input  logic                  slave_write,
    input  logic [bus_w-1:0]      slave_writedata,
    output logic                  slave_waitrequest,
    output logic [bus_w-1:0]      slave_readdata,
    input  logic                  run_done,
    input  logic [count_w-1:0]    move_count,
    output logic                  start,
    output logic [addr_w-1:0]     src,
    output logic [addr_w-1:0]     dest,
    output sq_idx_t               origin
);

    logic               wr_ok;
    logic               go;
    logic [2:0]         file_q;
    logic [2:0]         rank_q;
    logic [count_w-1:0] count_q;

    // a write only lands while the engine is idle
    assign wr_ok = slave_write && !slave_waitrequest;
    assign go    = wr_ok && slave_address == reg_start;

    assign origin = {rank_q, file_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start             <= 1'b0;
            slave_waitrequest <= 1'b0;
            count_q           <= '0;
        end else begin
            start <= go;
            // busy from the start pulse to the cycle after run_done
            if (go) begin
                slave_waitrequest <= 1'b1;
            end else if (run_done) begin
                slave_waitrequest <= 1'b0;
            end
            if (run_done) begin
                count_q <= move_count;
            end
        end
    end

    // argument registers
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            case (slave_address)
                reg_src:  src    <= slave_writedata[addr_w-1:0];
                reg_dest: dest   <= slave_writedata[addr_w-1:0];
                reg_file: file_q <= slave_writedata[2:0];
                reg_rank: rank_q <= slave_writedata[2:0];
                default: ;
            endcase
        end
    end

    // register 0 reads back the number of boards written by the last run
    always_comb begin
        slave_readdata = '0;
        if (slave_read) begin
            case (slave_address)
                reg_start: slave_readdata = bus_w'(count_q);
                reg_src:   slave_readdata = bus_w'(src);
                reg_dest:  slave_readdata = bus_w'(dest);
                reg_file:  slave_readdata = bus_w'(file_q);
                reg_rank:  slave_readdata = bus_w'(rank_q);
                default:   slave_readdata = '0;
            endcase
        end
    end

endmodule

// ==== src/ray_if.sv ====
`timescale 1ns/10ps

interface ray_if import chess_pkg::*; ();

    // mover side
    logic    start;
    sq_idx_t origin;
    colour_t own_colour;
    square_t probe_data;
    logic    taken;

    // scanner side
    sq_idx_t probe_sq;
    logic    target_valid;
    sq_idx_t target_sq;
    logic    scan_done;

    modport scanner (
        input  start, origin, own_colour, probe_data, taken,
        output probe_sq, target_valid, target_sq, scan_done
    );

    modport mover (
        output start, origin, own_colour, probe_data, taken,
        input  probe_sq, target_valid, target_sq, scan_done
    );

endinterface

// ==== src/bus_pkg.sv ====
package bus_pkg;

    // data width of both bus ports
    localparam int bus_w = 32;

    // slave register map
    localparam int reg_addr_w = 4;

    localparam logic [reg_addr_w-1:0] reg_start = 4'd0;
    localparam logic [reg_addr_w-1:0] reg_src   = 4'd1;
    localparam logic [reg_addr_w-1:0] reg_dest  = 4'd2;
    localparam logic [reg_addr_w-1:0] reg_file  = 4'd3;
    localparam logic [reg_addr_w-1:0] reg_rank  = 4'd4;

    // a queen has at most 27 moves
    localparam int count_w = 5;

endpackage

// ==== src/chess_pkg.sv ====
package chess_pkg;

    localparam int board_side = 8;
    localparam int board_squares = board_side * board_side;

    // square index is rank * 8 + file
    typedef logic [5:0] sq_idx_t;

    // ray coordinate, one step past either edge still fits
    typedef logic signed [4:0] coord_t;

    typedef struct packed {
        logic       sign;
        logic [6:0] kind;
    } piece_fields_t;

    // one board word, either as a signed piece code or split in sign and kind
    typedef union packed {
        logic signed [7:0] code;
        piece_fields_t     f;
    } square_t;

    typedef enum logic [1:0] {
        colour_empty,
        colour_white,
        colour_black
    } colour_t;

    // file and rank steps per ray, indexed [diagonal][ray]
    localparam coord_t ray_df [2][4] = '{'{5'sd0, 5'sd0, -5'sd1, 5'sd1},
                                         '{5'sd1, 5'sd1, -5'sd1, -5'sd1}};
    localparam coord_t ray_dr [2][4] = '{'{5'sd1, -5'sd1, 5'sd0, 5'sd0},
                                         '{5'sd1, -5'sd1, 5'sd1, -5'sd1}};

    function automatic colour_t square_colour(square_t sq);
        if (sq.code == '0) begin
            return colour_empty;
        end
        // negative codes are black
        if (sq.f.sign) begin
            return colour_black;
        end
        return colour_white;
    endfunction

endpackage
